/* logic/block_exponent_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module block_exponent_detector (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic signed [cbfp_fmt_pkg::IN_W-1:0]   di_re [cbfp_geom_pkg::LANES],
    input  logic signed [cbfp_fmt_pkg::IN_W-1:0]   di_im [cbfp_geom_pkg::LANES],
    input  logic                                   di_en,
    output logic        [cbfp_fmt_pkg::EXP_W-1:0]  blk_exp [cbfp_geom_pkg::NUM_BLKS],
    output logic                                   exp_valid
);

    import cbfp_fmt_pkg::*;
    import cbfp_geom_pkg::*;

    // bits below the sign that repeat it up to the first change
    function automatic logic [EXP_W-1:0] sign_run(input logic signed [IN_W-1:0] x);
        logic [EXP_W-1:0] cnt;
        logic             run;
        cnt = '0;
        run = 1'b1;
        for (int b = IN_W - 2; b >= 0; b--) begin
            if (run && (x[b] == x[IN_W-1])) begin
                cnt = cnt + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
        return cnt;
    endfunction

    logic [EXP_W-1:0] run_re [LANES];
    logic [EXP_W-1:0] run_im [LANES];
    logic [EXP_W-1:0] cnt_re [LANES];
    logic [EXP_W-1:0] cnt_im [LANES];
    logic             cnt_valid;
    logic [EXP_W-1:0] blk_min [NUM_BLKS];

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            run_re[l] = sign_run(di_re[l]);
            run_im[l] = sign_run(di_im[l]);
        end
    end

    // stage 1 holds the per-part counts
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt_valid <= 1'b0;
            for (int l = 0; l < LANES; l++) begin
                cnt_re[l] <= '0;
                cnt_im[l] <= '0;
            end
        end else begin
            cnt_valid <= di_en;
            if (di_en) begin
                for (int l = 0; l < LANES; l++) begin
                    cnt_re[l] <= run_re[l];
                    cnt_im[l] <= run_im[l];
                end
            end
        end
    end

    // smallest count over both parts of every lane in a block
    always_comb begin
        for (int b = 0; b < NUM_BLKS; b++) begin
            blk_min[b] = EXP_W'(EXP_MAX);
            for (int k = 0; k < BLK_LANES; k++) begin
                if (cnt_re[b * BLK_LANES + k] < blk_min[b]) begin
                    blk_min[b] = cnt_re[b * BLK_LANES + k];
                end
                if (cnt_im[b * BLK_LANES + k] < blk_min[b]) begin
                    blk_min[b] = cnt_im[b * BLK_LANES + k];
                end
            end
        end
    end

    // stage 2 holds the block exponents
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exp_valid <= 1'b0;
            for (int b = 0; b < NUM_BLKS; b++) begin
                blk_exp[b] <= '0;
            end
        end else begin
            exp_valid <= cnt_valid;
            if (cnt_valid) begin
                for (int b = 0; b < NUM_BLKS; b++) begin
                    blk_exp[b] <= blk_min[b];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/block_normalizer.sv */
`timescale 1ns/1ps
`default_nettype none

module block_normalizer (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic signed [cbfp_fmt_pkg::IN_W-1:0]   dl_re [cbfp_geom_pkg::LANES],
    input  logic signed [cbfp_fmt_pkg::IN_W-1:0]   dl_im [cbfp_geom_pkg::LANES],
    input  logic        [cbfp_fmt_pkg::EXP_W-1:0]  blk_exp [cbfp_geom_pkg::NUM_BLKS],
    input  logic                                   exp_valid,
    output logic signed [cbfp_fmt_pkg::OUT_W-1:0]  do_re [cbfp_geom_pkg::LANES],
    output logic signed [cbfp_fmt_pkg::OUT_W-1:0]  do_im [cbfp_geom_pkg::LANES],
    output logic        [cbfp_fmt_pkg::EXP_W-1:0]  do_index [cbfp_geom_pkg::NUM_BLKS],
    output logic                                   do_en
);

    import cbfp_fmt_pkg::*;
    import cbfp_geom_pkg::*;

    // scale by 2^(e - EXP_REF) and keep the low OUT_W bits
    function automatic logic signed [OUT_W-1:0] scale(
        input logic signed [IN_W-1:0] x,
        input logic [EXP_W-1:0]       e
    );
        logic signed [IN_W-1:0] y;
        if (e > EXP_W'(EXP_REF)) begin
            y = x <<< (e - EXP_W'(EXP_REF));
        end else if (e == EXP_W'(EXP_REF)) begin
            y = x;
        end else begin
            // arithmetic shift keeps the sign
            y = x >>> (EXP_W'(EXP_REF) - e);
        end
        return y[OUT_W-1:0];
    endfunction

    logic signed [OUT_W-1:0] scl_re [LANES];
    logic signed [OUT_W-1:0] scl_im [LANES];

    // lane k takes the exponent of block k / BLK_LANES
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            scl_re[l] = scale(dl_re[l], blk_exp[l / BLK_LANES]);
            scl_im[l] = scale(dl_im[l], blk_exp[l / BLK_LANES]);
        end
    end

    // outputs hold between valid sets
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            do_en <= 1'b0;
            for (int l = 0; l < LANES; l++) begin
                do_re[l] <= '0;
                do_im[l] <= '0;
            end
            for (int b = 0; b < NUM_BLKS; b++) begin
                do_index[b] <= '0;
            end
        end else begin
            do_en <= exp_valid;
            if (exp_valid) begin
                for (int l = 0; l < LANES; l++) begin
                    do_re[l] <= scl_re[l];
                    do_im[l] <= scl_im[l];
                end
                for (int b = 0; b < NUM_BLKS; b++) begin
                    do_index[b] <= blk_exp[b];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cbfp_fmt_pkg.sv */
`default_nettype none

// number formats along the normalizer datapath
package cbfp_fmt_pkg;

    // one real or imaginary part of an input sample
    localparam int IN_W = 25;

    // one part of a normalized output sample
    localparam int OUT_W = 12;

    // shared block exponent wide enough for 0 to EXP_MAX
    localparam int EXP_W = 5;

    // exponent at which a sample passes through without a shift
    // above it samples move left and below it they move right
    localparam int EXP_REF = 13;

    // largest redundant sign run which only 0 and -1 reach
    localparam int EXP_MAX = IN_W - 1;

endpackage

`default_nettype wire

/* logic/cbfp_geom_pkg.sv */
`default_nettype none

// lane layout and pipeline depth
package cbfp_geom_pkg;

    // complex lanes taken per cycle
    localparam int LANES = 16;

    // lanes sharing one exponent
    localparam int BLK_LANES = 8;
    localparam int NUM_BLKS = LANES / BLK_LANES;

    // register stages from di_en to exp_valid
    localparam int DET_STAGES = 2;

endpackage

`default_nettype wire

/* logic/cbfp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cbfp_top (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic signed [cbfp_fmt_pkg::IN_W-1:0]   di_re [cbfp_geom_pkg::LANES],
    input  logic signed [cbfp_fmt_pkg::IN_W-1:0]   di_im [cbfp_geom_pkg::LANES],
    input  logic                                   di_en,
    output logic signed [cbfp_fmt_pkg::OUT_W-1:0]  do_re [cbfp_geom_pkg::LANES],
    output logic signed [cbfp_fmt_pkg::OUT_W-1:0]  do_im [cbfp_geom_pkg::LANES],
    output logic        [cbfp_fmt_pkg::EXP_W-1:0]  do_index [cbfp_geom_pkg::NUM_BLKS],
    output logic                                   do_en
);

    import cbfp_fmt_pkg::*;
    import cbfp_geom_pkg::*;

    logic        [EXP_W-1:0] blk_exp [NUM_BLKS];
    logic                    exp_valid;

    // samples delayed to line up with blk_exp
    logic signed [IN_W-1:0]  dl_re [LANES];
    logic signed [IN_W-1:0]  dl_im [LANES];

    block_exponent_detector det_i (
        .clk       (clk),
        .rstn      (rstn),
        .di_re     (di_re),
        .di_im     (di_im),
        .di_en     (di_en),
        .blk_exp   (blk_exp),
        .exp_valid (exp_valid)
    );

    sample_delay_line dly_i (
        .clk   (clk),
        .rstn  (rstn),
        .di_re (di_re),
        .di_im (di_im),
        .dl_re (dl_re),
        .dl_im (dl_im)
    );

    block_normalizer norm_i (
        .clk       (clk),
        .rstn      (rstn),
        .dl_re     (dl_re),
        .dl_im     (dl_im),
        .blk_exp   (blk_exp),
        .exp_valid (exp_valid),
        .do_re     (do_re),
        .do_im     (do_im),
        .do_index  (do_index),
        .do_en     (do_en)
    );

endmodule

`default_nettype wire

/* logic/sample_delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_delay_line (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic signed [cbfp_fmt_pkg::IN_W-1:0]  di_re [cbfp_geom_pkg::LANES],
    input  logic signed [cbfp_fmt_pkg::IN_W-1:0]  di_im [cbfp_geom_pkg::LANES],
    output logic signed [cbfp_fmt_pkg::IN_W-1:0]  dl_re [cbfp_geom_pkg::LANES],
    output logic signed [cbfp_fmt_pkg::IN_W-1:0]  dl_im [cbfp_geom_pkg::LANES]
);

    import cbfp_fmt_pkg::*;
    import cbfp_geom_pkg::*;

    // one row per detector stage so samples meet their exponents
    logic signed [IN_W-1:0] pipe_re [DET_STAGES][LANES];
    logic signed [IN_W-1:0] pipe_im [DET_STAGES][LANES];

    // shifts every cycle and the detector valid marks the live sets
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < DET_STAGES; s++) begin
                for (int l = 0; l < LANES; l++) begin
                    pipe_re[s][l] <= '0;
                    pipe_im[s][l] <= '0;
                end
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                pipe_re[0][l] <= di_re[l];
                pipe_im[0][l] <= di_im[l];
            end
            for (int s = 1; s < DET_STAGES; s++) begin
                for (int l = 0; l < LANES; l++) begin
                    pipe_re[s][l] <= pipe_re[s-1][l];
                    pipe_im[s][l] <= pipe_im[s-1][l];
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            dl_re[l] = pipe_re[DET_STAGES-1][l];
            dl_im[l] = pipe_im[DET_STAGES-1][l];
        end
    end

endmodule

`default_nettype wire

/* project.f */
logic/cbfp_fmt_pkg.sv
logic/cbfp_geom_pkg.sv
logic/block_exponent_detector.sv
logic/sample_delay_line.sv
logic/block_normalizer.sv
logic/cbfp_top.sv
test/cbfp_props.sv
test/cbfp_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the normalizer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
SIM=cbfp_sim

verilator --binary --timing --assert \
    -f project.f \
    --top-module cbfp_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass, see $LOG"
    exit 1
fi

/* test/cbfp_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cbfp_props (
    input logic                              clk,
    input logic                              rstn,
    input logic                              di_en,
    input logic                              do_en,
    input logic [cbfp_fmt_pkg::EXP_W-1:0]    do_index [cbfp_geom_pkg::NUM_BLKS]
);

    import cbfp_fmt_pkg::*;
    import cbfp_geom_pkg::*;

    // do_en repeats di_en once the set has crossed all three stages
    en_latency: assert property (
        @(posedge clk) disable iff (!rstn)
        do_en == $past(di_en, 3)
    ) else $error("do_en does not repeat di_en three cycles later");

    // a sign run never exceeds IN_W - 1
    for (genvar b = 0; b < NUM_BLKS; b++) begin : g_idx
        idx_range: assert property (
            @(posedge clk)
            do_index[b] <= EXP_W'(EXP_MAX)
        ) else $error("do_index entry %0d above the largest exponent", b);
    end

    en_low_in_reset: assert property (
        @(posedge clk)
        !rstn |-> !do_en
    ) else $error("do_en high while reset is held");

endmodule

`default_nettype wire

/* test/cbfp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cbfp_tb;

    import cbfp_fmt_pkg::*;
    import cbfp_geom_pkg::*;

    localparam int LATENCY     = 3;
    localparam int DRIVE_DLY   = 2;
    localparam int NUM_SETS    = 400;
    localparam int DRAIN_LIMIT = 20;

    logic                    clk;
    logic                    rstn;
    logic signed [IN_W-1:0]  di_re [LANES];
    logic signed [IN_W-1:0]  di_im [LANES];
    logic                    di_en;
    logic signed [OUT_W-1:0] do_re [LANES];
    logic signed [OUT_W-1:0] do_im [LANES];
    logic [EXP_W-1:0]        do_index [NUM_BLKS];
    logic                    do_en;

    logic [31:0]               lfsr;
    logic [LATENCY-1:0]        en_hist;
    logic [LANES*OUT_W-1:0]    q_re [$];
    logic [LANES*OUT_W-1:0]    q_im [$];
    logic [NUM_BLKS*EXP_W-1:0] q_idx [$];
    // outputs must keep these while do_en is low
    logic [LANES*OUT_W-1:0]    hold_re;
    logic [LANES*OUT_W-1:0]    hold_im;
    logic [NUM_BLKS*EXP_W-1:0] hold_idx;
    int                        checks;
    int                        mismatches;
    int                        timeouts;

    cbfp_top dut_i (
        .clk      (clk),
        .rstn     (rstn),
        .di_re    (di_re),
        .di_im    (di_im),
        .di_en    (di_en),
        .do_re    (do_re),
        .do_im    (do_im),
        .do_index (do_index),
        .do_en    (do_en)
    );

    bind cbfp_top cbfp_props props_i (
        .clk      (clk),
        .rstn     (rstn),
        .di_en    (di_en),
        .do_en    (do_en),
        .do_index (do_index)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // n redundant sign bits means x fits in IN_W - n signed bits
    function automatic int sign_bits(input logic signed [IN_W-1:0] x);
        int     n;
        longint v;
        longint lim;
        v = longint'(x);
        n = 0;
        lim = longint'(1) << (IN_W - 2);
        while (n < IN_W - 1 && v >= -lim && v < lim) begin
            n++;
            lim = lim >>> 1;
        end
        return n;
    endfunction

    // x * 2^(e - EXP_REF) rounded toward minus infinity and cut to OUT_W bits
    function automatic logic [OUT_W-1:0] scaled(input logic signed [IN_W-1:0] x, input int e);
        longint v;
        v = longint'(x);
        if (e >= EXP_REF) begin
            v = v * (longint'(1) << (e - EXP_REF));
        end else begin
            v = v >>> (EXP_REF - e);
        end
        return v[OUT_W-1:0];
    endfunction

    // classes 0 to 3 give full range and 4 to 5 small values
    // class 6 gives all zeros and class 7 all ones
    task automatic make_part(input logic [2:0] cls, input int w,
                             output logic signed [IN_W-1:0] x);
        logic [31:0] v;
        take_bits(IN_W, v);
        x = v[IN_W-1:0];
        if (cls == 3'd4 || cls == 3'd5) begin
            x = (x <<< (IN_W - w)) >>> (IN_W - w);
        end else if (cls == 3'd6) begin
            x = '0;
        end else if (cls == 3'd7) begin
            x = '1;
        end
    endtask

    task automatic gen_set(input logic allow_en);
        logic [31:0] v;
        logic [2:0]  cls;
        int          w;
        for (int b = 0; b < NUM_BLKS; b++) begin
            take_bits(3, v);
            cls = v[2:0];
            take_bits(4, v);
            w = int'(v[3:0]) % 12 + 1;
            for (int k = 0; k < BLK_LANES; k++) begin
                make_part(cls, w, di_re[b * BLK_LANES + k]);
                make_part(cls, w, di_im[b * BLK_LANES + k]);
            end
        end
        take_bits(2, v);
        di_en = allow_en && (v[1:0] != 2'b00);
    endtask

    task automatic push_expected();
        int                        e [NUM_BLKS];
        int                        s;
        logic [LANES*OUT_W-1:0]    er;
        logic [LANES*OUT_W-1:0]    ei;
        logic [NUM_BLKS*EXP_W-1:0] ex;
        for (int b = 0; b < NUM_BLKS; b++) begin
            e[b] = EXP_MAX;
            for (int k = 0; k < BLK_LANES; k++) begin
                s = sign_bits(di_re[b * BLK_LANES + k]);
                if (s < e[b]) e[b] = s;
                s = sign_bits(di_im[b * BLK_LANES + k]);
                if (s < e[b]) e[b] = s;
            end
            ex[b*EXP_W +: EXP_W] = EXP_W'(e[b]);
        end
        for (int l = 0; l < LANES; l++) begin
            er[l*OUT_W +: OUT_W] = scaled(di_re[l], e[l / BLK_LANES]);
            ei[l*OUT_W +: OUT_W] = scaled(di_im[l], e[l / BLK_LANES]);
        end
        q_re.push_back(er);
        q_im.push_back(ei);
        q_idx.push_back(ex);
    endtask

    task automatic check_outputs();
        checks++;
        assert (do_en === en_hist[LATENCY-1]) else begin
            $display("[FAIL] do_en expected %0h got %0h", en_hist[LATENCY-1], do_en);
            mismatches++;
        end
        if (en_hist[LATENCY-1]) begin
            assert (q_re.size() > 0) else begin
                $display("an output set was due but the model had none queued");
                mismatches++;
            end
            if (q_re.size() > 0) begin
                hold_re = q_re.pop_front();
                hold_im = q_im.pop_front();
                hold_idx = q_idx.pop_front();
            end
        end
        for (int b = 0; b < NUM_BLKS; b++) begin
            assert (do_index[b] === hold_idx[b*EXP_W +: EXP_W]) else begin
                $display("[FAIL] do_index block %0d expected %0h got %0h",
                         b, hold_idx[b*EXP_W +: EXP_W], do_index[b]);
                mismatches++;
            end
        end
        for (int l = 0; l < LANES; l++) begin
            assert (do_re[l] === hold_re[l*OUT_W +: OUT_W]) else begin
                $display("[FAIL] do_re lane %0d expected %0h got %0h",
                         l, hold_re[l*OUT_W +: OUT_W], do_re[l]);
                mismatches++;
            end
            assert (do_im[l] === hold_im[l*OUT_W +: OUT_W]) else begin
                $display("[FAIL] do_im lane %0d expected %0h got %0h",
                         l, hold_im[l*OUT_W +: OUT_W], do_im[l]);
                mismatches++;
            end
        end
    endtask

    task automatic run_cycle(input logic allow_en);
        @(posedge clk);
        #DRIVE_DLY;
        check_outputs();
        gen_set(allow_en);
        if (di_en) push_expected();
        en_hist = {en_hist[LATENCY-2:0], di_en};
    endtask

    // sets still in flight are dropped by the DUT and by the model
    task automatic apply_reset();
        rstn = 1'b0;
        di_en = 1'b0;
        q_re.delete();
        q_im.delete();
        q_idx.delete();
        en_hist = '0;
        hold_re = '0;
        hold_im = '0;
        hold_idx = '0;
        repeat (3) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_outputs();
        end
        rstn = 1'b1;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (q_re.size() > 0 && waited < DRAIN_LIMIT) begin
            run_cycle(1'b0);
            waited++;
        end
        assert (q_re.size() == 0) else begin
            $display("timeout: %0d expected sets never left the DUT", q_re.size());
            timeouts++;
        end
    endtask

    initial begin
        lfsr = 32'h64b5;
        rstn = 1'b0;
        di_en = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            di_re[l] = '0;
            di_im[l] = '0;
        end
        checks = 0;
        mismatches = 0;
        timeouts = 0;
        apply_reset();
        repeat (NUM_SETS) run_cycle(1'b1);
        // second reset lands with sets in flight
        apply_reset();
        repeat (NUM_SETS / 2) run_cycle(1'b1);
        drain();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
